//--- build.f
verilog/axi_xbar_pkg.sv
verilog/ar_req_if.sv
verilog/read_request_port.sv
verilog/read_arbiter.sv
verilog/read_response_router.sv
verilog/read_crossbar.sv
verification/read_crossbar_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the read crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module read_crossbar_tb -o sim_read_crossbar
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_read_crossbar > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

//--- verification/read_crossbar_tb.sv
module read_crossbar_tb;
    import axi_xbar_pkg::*;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        len_t  len;
    } req_t;

    logic clock, reset;
    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready, fetch_rlast;
    logic data_arvalid, data_arready, data_rvalid, data_rready, data_rlast;
    logic master_arvalid, master_arready, master_rvalid, master_rready, master_rlast;
    addr_t fetch_araddr, data_araddr, master_araddr;
    id_t fetch_arid, data_arid, master_arid, fetch_rid, data_rid, master_rid;
    len_t fetch_arlen, data_arlen, master_arlen;
    size_t fetch_arsize, data_arsize, master_arsize;
    burst_t fetch_arburst, data_arburst, master_arburst;
    data_t fetch_rdata, data_rdata, master_rdata;
    resp_t fetch_rresp, data_rresp, master_rresp;

    req_t fetch_pend[$], data_pend[$];  // accepted, not yet issued
    req_t fetch_exp[$], data_exp[$];    // issued, beats still owed
    req_t slave_q[$];
    req_t s_req, held, cur;
    logic [15:0] lfsr = 16'd26;
    bit burst_open, ar_stalled, tie_at_start, ar_fire, r_fire, r_active;
    bit cur_owner;
    bit last_owner = 1'b1;  // data counts as last granted out of reset
    int beat, s_beat, accepted_cnt, done_cnt;
    int fetch_seq, data_seq;

    read_crossbar read_crossbar_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // galois lfsr, one step per bit
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic fail_text(input string what);
        $display("FAIL at %0t: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped on first error");
    endtask

    task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        fail_text($sformatf("%s got %h expected %h", name, got, exp));
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    assert property (@(posedge clock) disable iff (reset) !(master_arvalid && burst_open))
        else fail_value("master_arvalid", master_arvalid, 0);

    always @(posedge clock) begin
        if (!reset) begin
            // router steering, judged on the pre-edge burst state
            if (!burst_open) begin
                check_eq("master_rready", master_rready, 0);
                check_eq("fetch_rvalid", fetch_rvalid, 0);
                check_eq("data_rvalid", data_rvalid, 0);
            end else if (cur_owner == 1'b0) begin
                check_eq("fetch_rvalid", fetch_rvalid, master_rvalid);
                check_eq("data_rvalid", data_rvalid, 0);
                check_eq("master_rready", master_rready, fetch_rready);
            end else begin
                check_eq("data_rvalid", data_rvalid, master_rvalid);
                check_eq("fetch_rvalid", fetch_rvalid, 0);
                check_eq("master_rready", master_rready, data_rready);
            end
            r_fire = master_rvalid && master_rready;
            if (r_fire) begin
                cur = cur_owner ? data_exp[0] : fetch_exp[0];
                check_eq("rid", cur_owner ? data_rid : fetch_rid, cur.id);
                check_eq("rdata", cur_owner ? data_rdata : fetch_rdata,
                         64'(cur.addr) + 64'(8 * beat));
                check_eq("rresp", cur_owner ? data_rresp : fetch_rresp, 0);
                check_eq("rlast", cur_owner ? data_rlast : fetch_rlast, beat == cur.len);
                beat++;
                if (beat > cur.len) begin
                    if (cur_owner) void'(data_exp.pop_front());
                    else void'(fetch_exp.pop_front());
                    beat = 0;
                    burst_open = 0;
                    done_cnt++;
                end
            end
            // AR held steady under back-pressure
            if (ar_stalled) begin
                check_eq("master_arvalid", master_arvalid, 1);
                check_eq("master_araddr", master_araddr, held.addr);
                check_eq("master_arid", master_arid, held.id);
                check_eq("master_arlen", master_arlen, held.len);
            end else if (master_arvalid) begin
                tie_at_start = fetch_pend.size() != 0 && data_pend.size() != 0;
            end
            ar_fire = master_arvalid && master_arready;
            if (ar_fire) begin
                cur_owner = master_arid[ID_W-1];  // id top bit marks the requester
                if (tie_at_start)
                    assert (cur_owner != last_owner)
                        else fail_text("tie granted to the same requester twice in a row");
                assert ((cur_owner ? data_pend.size() : fetch_pend.size()) != 0)
                    else fail_text("master AR issued with no pending request for that id");
                cur = cur_owner ? data_pend.pop_front() : fetch_pend.pop_front();
                check_eq("master_araddr", master_araddr, cur.addr);
                check_eq("master_arid", master_arid, cur.id);
                check_eq("master_arlen", master_arlen, cur.len);
                check_eq("master_arsize", master_arsize, 3'd3);
                check_eq("master_arburst", master_arburst, 2'b01);
                if (cur_owner) data_exp.push_back(cur);
                else fetch_exp.push_back(cur);
                slave_q.push_back(cur);
                last_owner = cur_owner;
                burst_open = 1;
            end
            ar_stalled = master_arvalid && !master_arready;
            held = '{master_araddr, master_arid, master_arlen};
            if (fetch_arvalid && fetch_arready) begin
                fetch_pend.push_back('{fetch_araddr, fetch_arid, fetch_arlen});
                accepted_cnt++;
            end
            if (data_arvalid && data_arready) begin
                data_pend.push_back('{data_araddr, data_arid, data_arlen});
                accepted_cnt++;
            end
        end
    end

    // slave model and random ready on the requester side
    always @(negedge clock) begin
        if (!reset) begin
            if (r_fire) begin
                if (master_rlast) r_active = 0;
                else s_beat++;
                master_rvalid = 1'b0;
            end
            if (!r_active && slave_q.size() != 0) begin
                s_req = slave_q.pop_front();
                s_beat = 0;
                r_active = 1;
            end
            if (r_active && !master_rvalid) begin
                master_rvalid = take_bits(1) | take_bits(1);
                master_rdata = 64'(s_req.addr) + 64'(8 * s_beat);
                master_rlast = s_beat == s_req.len;
                master_rid = s_req.id;
            end
            master_arready = take_bits(1) | take_bits(1);
            fetch_rready = take_bits(1) | take_bits(1);
            data_rready = take_bits(1) | take_bits(1);
        end
    end

    task automatic send_request(input bit side, input addr_t addr, input len_t len);
        int waited;
        bit got;
        @(negedge clock);
        if (side) begin
            data_arvalid = 1;
            data_araddr = addr;
            data_arlen = len;
            data_arid = {1'b1, 3'(data_seq)};
            data_arsize = 3'd3;
            data_arburst = 2'b01;
            data_seq++;
        end else begin
            fetch_arvalid = 1;
            fetch_araddr = addr;
            fetch_arlen = len;
            fetch_arid = {1'b0, 3'(fetch_seq)};
            fetch_arsize = 3'd3;
            fetch_arburst = 2'b01;
            fetch_seq++;
        end
        waited = 0;
        got = 0;
        while (!got) begin
            @(posedge clock);
            got = side ? data_arready : fetch_arready;
            waited++;
            if (waited > 2000) fail_text("request was never accepted");
        end
        @(negedge clock);
        if (side) data_arvalid = 0;
        else fetch_arvalid = 0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (done_cnt != accepted_cnt || fetch_pend.size() != 0 || data_pend.size() != 0) begin
            @(posedge clock);
            waited++;
            if (waited > 20000) fail_text("outstanding requests never completed");
        end
    endtask

    task automatic random_traffic(input bit side);
        repeat (20) begin
            repeat (take_bits(2)) @(negedge clock);
            send_request(side, addr_t'(take_bits(16)) << 3, len_t'(take_bits(3)));
        end
    endtask

    initial begin
        reset = 1;
        fetch_arvalid = 0;
        fetch_araddr = '0;
        fetch_arid = '0;
        fetch_arlen = '0;
        fetch_arsize = '0;
        fetch_arburst = '0;
        fetch_rready = 0;
        data_arvalid = 0;
        data_araddr = '0;
        data_arid = '0;
        data_arlen = '0;
        data_arsize = '0;
        data_arburst = '0;
        data_rready = 0;
        master_arready = 0;
        master_rvalid = 0;
        master_rdata = '0;
        master_rresp = '0;
        master_rlast = 0;
        master_rid = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 0;
        check_eq("master_arvalid", master_arvalid, 0);
        check_eq("master_rready", master_rready, 0);
        check_eq("fetch_rvalid", fetch_rvalid, 0);
        check_eq("data_rvalid", data_rvalid, 0);
        check_eq("fetch_arready", fetch_arready, 1);
        check_eq("data_arready", data_arready, 1);
        // first tie out of reset goes to fetch
        fork
            begin
                send_request(0, 32'h3000, 8'd2);
                send_request(0, 32'h3100, 8'd1);
            end
            begin
                send_request(1, 32'h4000, 8'd2);
                send_request(1, 32'h4100, 8'd0);
            end
        join
        wait_idle();
        send_request(0, 32'h0000_1000, 8'd3);
        wait_idle();
        send_request(1, 32'h0000_2000, 8'd5);
        wait_idle();
        fork
            random_traffic(0);
            random_traffic(1);
        join
        wait_idle();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- verilog/read_crossbar.sv
module read_crossbar (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  fetch_arvalid,
    output logic                  fetch_arready,
    input  axi_xbar_pkg::addr_t   fetch_araddr,
    input  axi_xbar_pkg::id_t     fetch_arid,
    input  axi_xbar_pkg::len_t    fetch_arlen,
    input  axi_xbar_pkg::size_t   fetch_arsize,
    input  axi_xbar_pkg::burst_t  fetch_arburst,
    output logic                  fetch_rvalid,
    input  logic                  fetch_rready,
    output axi_xbar_pkg::data_t   fetch_rdata,
    output axi_xbar_pkg::resp_t   fetch_rresp,
    output logic                  fetch_rlast,
    output axi_xbar_pkg::id_t     fetch_rid,

    input  logic                  data_arvalid,
    output logic                  data_arready,
    input  axi_xbar_pkg::addr_t   data_araddr,
    input  axi_xbar_pkg::id_t     data_arid,
    input  axi_xbar_pkg::len_t    data_arlen,
    input  axi_xbar_pkg::size_t   data_arsize,
    input  axi_xbar_pkg::burst_t  data_arburst,
    output logic                  data_rvalid,
    input  logic                  data_rready,
    output axi_xbar_pkg::data_t   data_rdata,
    output axi_xbar_pkg::resp_t   data_rresp,
    output logic                  data_rlast,
    output axi_xbar_pkg::id_t     data_rid,

    output logic                  master_arvalid,
    input  logic                  master_arready,
    output axi_xbar_pkg::addr_t   master_araddr,
    output axi_xbar_pkg::id_t     master_arid,
    output axi_xbar_pkg::len_t    master_arlen,
    output axi_xbar_pkg::size_t   master_arsize,
    output axi_xbar_pkg::burst_t  master_arburst,
    input  logic                  master_rvalid,
    output logic                  master_rready,
    input  axi_xbar_pkg::data_t   master_rdata,
    input  axi_xbar_pkg::resp_t   master_rresp,
    input  logic                  master_rlast,
    input  axi_xbar_pkg::id_t     master_rid
);
    import axi_xbar_pkg::*;

    logic       issue;
    requester_t issue_owner;
    logic       busy;

    ar_req_if fetch_req ();
    ar_req_if data_req ();

    read_request_port fetch_port (
        .clock   (clock),
        .reset   (reset),
        .arvalid (fetch_arvalid),
        .arready (fetch_arready),
        .araddr  (fetch_araddr),
        .arid    (fetch_arid),
        .arlen   (fetch_arlen),
        .arsize  (fetch_arsize),
        .arburst (fetch_arburst),
        .req     (fetch_req)
    );

    read_request_port data_port (
        .clock   (clock),
        .reset   (reset),
        .arvalid (data_arvalid),
        .arready (data_arready),
        .araddr  (data_araddr),
        .arid    (data_arid),
        .arlen   (data_arlen),
        .arsize  (data_arsize),
        .arburst (data_arburst),
        .req     (data_req)
    );

    read_arbiter arbiter (
        .clock          (clock),
        .reset          (reset),
        .fetch_req      (fetch_req),
        .data_req       (data_req),
        .busy           (busy),
        .master_arvalid (master_arvalid),
        .master_arready (master_arready),
        .master_araddr  (master_araddr),
        .master_arid    (master_arid),
        .master_arlen   (master_arlen),
        .master_arsize  (master_arsize),
        .master_arburst (master_arburst),
        .issue          (issue),
        .issue_owner    (issue_owner)
    );

    read_response_router router (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .issue_owner   (issue_owner),
        .busy          (busy),
        .master_rvalid (master_rvalid),
        .master_rready (master_rready),
        .master_rdata  (master_rdata),
        .master_rresp  (master_rresp),
        .master_rlast  (master_rlast),
        .master_rid    (master_rid),
        .fetch_rvalid  (fetch_rvalid),
        .fetch_rready  (fetch_rready),
        .fetch_rdata   (fetch_rdata),
        .fetch_rresp   (fetch_rresp),
        .fetch_rlast   (fetch_rlast),
        .fetch_rid     (fetch_rid),
        .data_rvalid   (data_rvalid),
        .data_rready   (data_rready),
        .data_rdata    (data_rdata),
        .data_rresp    (data_rresp),
        .data_rlast    (data_rlast),
        .data_rid      (data_rid)
    );

endmodule

//--- verilog/read_response_router.sv
module read_response_router (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue,
    input  axi_xbar_pkg::requester_t issue_owner,
    output logic                     busy,
    input  logic                     master_rvalid,
    output logic                     master_rready,
    input  axi_xbar_pkg::data_t      master_rdata,
    input  axi_xbar_pkg::resp_t      master_rresp,
    input  logic                     master_rlast,
    input  axi_xbar_pkg::id_t        master_rid,
    output logic                     fetch_rvalid,
    input  logic                     fetch_rready,
    output axi_xbar_pkg::data_t      fetch_rdata,
    output axi_xbar_pkg::resp_t      fetch_rresp,
    output logic                     fetch_rlast,
    output axi_xbar_pkg::id_t        fetch_rid,
    output logic                     data_rvalid,
    input  logic                     data_rready,
    output axi_xbar_pkg::data_t      data_rdata,
    output axi_xbar_pkg::resp_t      data_rresp,
    output logic                     data_rlast,
    output axi_xbar_pkg::id_t        data_rid
);
    import axi_xbar_pkg::*;

    requester_t owner;
    logic       to_fetch;
    logic       to_data;
    logic       last_beat;

    assign to_fetch  = busy & (owner == REQ_FETCH);
    assign to_data   = busy & (owner == REQ_DATA);
    assign last_beat = master_rvalid & master_rready & master_rlast;

    // one burst in flight at a time
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= REQ_FETCH;
        end else if (issue) begin
            busy  <= 1'b1;
            owner <= issue_owner;
        end else if (last_beat) begin
            busy  <= 1'b0;
        end
    end

    assign master_rready = (to_fetch & fetch_rready) | (to_data & data_rready);

    assign fetch_rvalid = to_fetch & master_rvalid;
    assign data_rvalid  = to_data & master_rvalid;

    // payload fans out, only valid is steered
    assign fetch_rdata = master_rdata;
    assign fetch_rresp = master_rresp;
    assign fetch_rlast = master_rlast;
    assign fetch_rid   = master_rid;

    assign data_rdata  = master_rdata;
    assign data_rresp  = master_rresp;
    assign data_rlast  = master_rlast;
    assign data_rid    = master_rid;

endmodule

//--- verilog/read_arbiter.sv
module read_arbiter (
    input  logic                     clock,
    input  logic                     reset,
    ar_req_if.sink                   fetch_req,
    ar_req_if.sink                   data_req,
    input  logic                     busy,
    output logic                     master_arvalid,
    input  logic                     master_arready,
    output axi_xbar_pkg::addr_t      master_araddr,
    output axi_xbar_pkg::id_t        master_arid,
    output axi_xbar_pkg::len_t       master_arlen,
    output axi_xbar_pkg::size_t      master_arsize,
    output axi_xbar_pkg::burst_t     master_arburst,
    output logic                     issue,
    output axi_xbar_pkg::requester_t issue_owner
);
    import axi_xbar_pkg::*;

    requester_t last_grant;
    logic       locked;      // choice held under arready back-pressure
    requester_t locked_owner;
    requester_t pick;
    requester_t owner;
    logic       any_valid;

    assign any_valid = fetch_req.valid | data_req.valid;

    // round robin, the side not granted last wins a tie
    always_comb begin
        if (fetch_req.valid && data_req.valid) begin
            pick = (last_grant == REQ_FETCH) ? REQ_DATA : REQ_FETCH;
        end else if (fetch_req.valid) begin
            pick = REQ_FETCH;
        end else begin
            pick = REQ_DATA;
        end
    end

    assign owner          = locked ? locked_owner : pick;
    assign master_arvalid = locked | (~busy & any_valid);
    assign issue          = master_arvalid & master_arready;
    assign issue_owner    = owner;

    always_comb begin
        if (owner == REQ_FETCH) begin
            master_araddr  = fetch_req.addr;
            master_arid    = fetch_req.id;
            master_arlen   = fetch_req.len;
            master_arsize  = fetch_req.size;
            master_arburst = fetch_req.burst;
        end else begin
            master_araddr  = data_req.addr;
            master_arid    = data_req.id;
            master_arlen   = data_req.len;
            master_arsize  = data_req.size;
            master_arburst = data_req.burst;
        end
    end

    // slot drains on the same edge as the master transfer
    assign fetch_req.ready = issue & (owner == REQ_FETCH);
    assign data_req.ready  = issue & (owner == REQ_DATA);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            locked       <= 1'b0;
            locked_owner <= REQ_FETCH;
        end else begin
            locked       <= master_arvalid & ~master_arready;
            locked_owner <= owner;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            last_grant <= REQ_DATA;  // fetch takes the first tie
        end else if (issue) begin
            last_grant <= owner;
        end
    end

endmodule

//--- verilog/read_request_port.sv
module read_request_port (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  arvalid,
    output logic                  arready,
    input  axi_xbar_pkg::addr_t   araddr,
    input  axi_xbar_pkg::id_t     arid,
    input  axi_xbar_pkg::len_t    arlen,
    input  axi_xbar_pkg::size_t   arsize,
    input  axi_xbar_pkg::burst_t  arburst,
    ar_req_if.source              req
);
    import axi_xbar_pkg::*;

    logic   slot_empty;
    addr_t  slot_addr;
    id_t    slot_id;
    len_t   slot_len;
    size_t  slot_size;
    burst_t slot_burst;

    logic accept;
    logic drain;

    assign accept = arvalid & slot_empty;
    assign drain  = req.valid & req.ready;

    // empty flag doubles as the registered arready
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            slot_empty <= 1'b1;
        end else if (accept) begin
            slot_empty <= 1'b0;
        end else if (drain) begin
            slot_empty <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            slot_addr  <= araddr;
            slot_id    <= arid;
            slot_len   <= arlen;
            slot_size  <= arsize;
            slot_burst <= arburst;
        end
    end

    assign arready   = slot_empty;
    assign req.valid = ~slot_empty;
    assign req.addr  = slot_addr;
    assign req.id    = slot_id;
    assign req.len   = slot_len;
    assign req.size  = slot_size;
    assign req.burst = slot_burst;

endmodule

//--- verilog/ar_req_if.sv
interface ar_req_if;
    import axi_xbar_pkg::*;

    logic   valid;
    logic   ready;
    addr_t  addr;
    id_t    id;
    len_t   len;
    size_t  size;
    burst_t burst;

    // request slot side
    modport source (
        output valid, addr, id, len, size, burst,
        input  ready
    );

    // arbiter side
    modport sink (
        input  valid, addr, id, len, size, burst,
        output ready
    );

endinterface

//--- verilog/axi_xbar_pkg.sv
package axi_xbar_pkg;

    // bus widths, read side only
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;  // beats = len + 1

    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ID_W-1:0]    id_t;
    typedef logic [LEN_W-1:0]   len_t;

    typedef logic [SIZE_W-1:0]  size_t;   // bytes per beat, log2
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [RESP_W-1:0]  resp_t;

    // owner of a grant on the master port
    typedef enum logic [0:0] {
        REQ_FETCH = 1'b0,
        REQ_DATA  = 1'b1
    } requester_t;

endpackage
